//--- common/hazardPkg.sv
// hazard control package
// instruction word views, function classes, Tuse/Tnew widths, kernel-control codes
package hazardPkg;

    // instruction word, decoded either as R-type or I-type fields
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrWord;

    localparam int widthT = 3;                   // every Tuse / Tnew value
    localparam logic [widthT-1:0] tUseInf = 3'd7; // operand never read

    // function classes
    localparam int widthFunc = 3;
    localparam logic [widthFunc-1:0] funcNop      = 3'd0;
    localparam logic [widthFunc-1:0] funcCalcR    = 3'd1;
    localparam logic [widthFunc-1:0] funcCalcI    = 3'd2;
    localparam logic [widthFunc-1:0] funcMemRead  = 3'd3;
    localparam logic [widthFunc-1:0] funcMemWrite = 3'd4;
    localparam logic [widthFunc-1:0] funcBranch   = 3'd5;
    localparam logic [widthFunc-1:0] funcJump     = 3'd6;
    localparam logic [widthFunc-1:0] funcMultDiv  = 3'd7;

    // opcodes of the supported subset
    localparam logic [5:0] opSpecial = 6'h00; // R-type, decoded by funct
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;

    // funct codes under opSpecial
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnMflo = 6'h12;
    localparam logic [5:0] fnMult = 6'h18;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;

    localparam logic [31:0] instrNop = 32'h0000_0000;
    localparam logic [4:0]  regRa    = 5'd31; // link register for JAL

    // producer tracking
    localparam int numSlots = 3; // EX, MEM, WB
    localparam int slotEx   = 0;
    localparam int slotMem  = 1;

    // kernel control from CP0
    localparam int widthKCtrl = 2;
    localparam logic [widthKCtrl-1:0] kCtrlNone  = 2'd0;
    localparam logic [widthKCtrl-1:0] kCtrlKText = 2'd1; // enter handler
    localparam logic [widthKCtrl-1:0] kCtrlEret  = 2'd2; // return from handler

endpackage

//--- hazardControl/instrTiming.sv
`timescale 1ns/10ps
// instruction timing decoder
// classifies the ID instruction and gives its destination, Tuse per source and Tnew at ID
module instrTiming (
    input  hazardPkg::instrWord               instr,
    output logic [hazardPkg::widthFunc-1:0]   funcClass,
    output logic [4:0]                        dest,
    output logic [hazardPkg::widthT-1:0]      tUseRs,
    output logic [hazardPkg::widthT-1:0]      tUseRt,
    output logic [hazardPkg::widthT-1:0]      tNewId
);
    import hazardPkg::*;

    logic [widthT-1:0] tNewRaw;
    logic              isSll;
    logic              isLui;

    assign isSll = (instr.rType.opcode == opSpecial) && (instr.rType.funct == fnSll);
    assign isLui = (instr.iType.opcode == opLui);

    // class and destination
    always_comb begin
        funcClass = funcNop;
        dest      = 5'd0;
        if (instr != instrNop) begin
            case (instr.rType.opcode)
                opSpecial: begin
                    case (instr.rType.funct)
                        fnAddu, fnSubu, fnSll: begin
                            funcClass = funcCalcR;
                            dest      = instr.rType.rd;
                        end
                        fnJr:   funcClass = funcJump;
                        fnMult: funcClass = funcMultDiv;
                        fnMflo: begin
                            funcClass = funcMultDiv;
                            dest      = instr.rType.rd;
                        end
                        default: funcClass = funcNop; // unsupported funct
                    endcase
                end
                opOri, opLui: begin
                    funcClass = funcCalcI;
                    dest      = instr.iType.rt;
                end
                opLw: begin
                    funcClass = funcMemRead;
                    dest      = instr.iType.rt;
                end
                opSw:  funcClass = funcMemWrite;
                opBeq: funcClass = funcBranch;
                opJal: begin
                    funcClass = funcJump;
                    dest      = regRa;
                end
                default: funcClass = funcNop;
            endcase
        end
    end

    // Tuse / Tnew by class
    always_comb begin
        tUseRs  = tUseInf;
        tUseRt  = tUseInf;
        tNewRaw = '0;
        case (funcClass)
            funcCalcR: begin
                tUseRs  = isSll ? tUseInf : 3'd1; // shift reads rt only
                tUseRt  = 3'd1;
                tNewRaw = 3'd2;
            end
            funcCalcI: begin
                tUseRs  = isLui ? tUseInf : 3'd1;
                tNewRaw = isLui ? 3'd1 : 3'd2;
            end
            funcMemRead: begin
                tUseRs  = 3'd1;
                tNewRaw = 3'd3;
            end
            funcMemWrite: begin
                tUseRs = 3'd1; // address
                tUseRt = 3'd2; // store data needed in MEM
            end
            funcBranch: begin
                tUseRs = 3'd0; // compared in ID
                tUseRt = 3'd0;
            end
            funcJump: begin
                if (instr.rType.opcode == opSpecial) begin
                    tUseRs = 3'd0; // JR target
                end else begin
                    tNewRaw = 3'd1; // JAL link value
                end
            end
            funcMultDiv: begin
                if (instr.rType.funct == fnMult) begin
                    tUseRs = 3'd1;
                    tUseRt = 3'd1;
                end else begin
                    tNewRaw = 3'd2; // MFLO
                end
            end
            default: tNewRaw = '0;
        endcase
    end

    // writes to $0 produce nothing to wait for
    assign tNewId = (dest == 5'd0) ? '0 : tNewRaw;

    // a Tnew with no destination only comes from a $0 register field
    always_comb begin
        if (!$isunknown(instr)) begin
            assert final (dest != 5'd0 || tNewRaw == '0 ||
                          funcClass inside {funcCalcR, funcCalcI, funcMemRead, funcMultDiv})
                else $error("instrTiming: Tnew for an instruction that writes no register");
        end
    end

endmodule

//--- hazardControl/producerSlot.sv
`timescale 1ns/10ps
// producer slot
// one stage of the in-flight producer chain, counts remaining Tnew down as it moves
module producerSlot (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         advance,
    input  logic                         flush,
    input  logic                         prevValid,
    input  logic [4:0]                   prevDest,
    input  logic [hazardPkg::widthT-1:0] prevTnew,
    input  logic [31:0]                  prevPc,
    input  logic                         countDown,
    output logic                         valid,
    output logic [4:0]                   dest,
    output logic [hazardPkg::widthT-1:0] tNew,
    output logic [31:0]                  pc
);
    import hazardPkg::*;

    logic [widthT-1:0] tNext;

    // saturating decrement
    assign tNext = (countDown && prevTnew != '0) ? prevTnew - 1'b1 : prevTnew;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid <= 1'b0;
            dest  <= 5'd0;
            tNew  <= '0;
        end else if (flush) begin
            valid <= 1'b0;
            dest  <= 5'd0;
            tNew  <= '0;
        end else if (advance) begin
            valid <= prevValid;
            dest  <= prevDest;
            tNew  <= tNext;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pc <= prevPc;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) tNew <= widthT'(4))
        else $error("producerSlot: remaining Tnew above 4");

endmodule

//--- hazardControl/stallDetect.sv
`timescale 1ns/10ps
// stall detector
// Tuse/Tnew check of the ID sources against EX and MEM producers, plus mult/div busy
module stallDetect (
    input  logic [4:0]                      addrRs,
    input  logic [4:0]                      addrRt,
    input  logic [hazardPkg::widthT-1:0]    tUseRs,
    input  logic [hazardPkg::widthT-1:0]    tUseRt,
    input  logic [hazardPkg::widthFunc-1:0] funcClass,
    input  logic                            exValid,
    input  logic [4:0]                      exDest,
    input  logic [hazardPkg::widthT-1:0]    exTnew,
    input  logic                            memValid,
    input  logic [4:0]                      memDest,
    input  logic [hazardPkg::widthT-1:0]    memTnew,
    input  logic                            mdBusy,
    input  logic                            inValid,
    input  logic                            outReady,
    input  logic                            flush,
    output logic                            stallPc,
    output logic                            stallId,
    output logic                            stallClrEx,
    output logic                            issue,
    output logic                            inReady
);
    import hazardPkg::*;

    logic exHitRs;
    logic memHitRs;
    logic exHitRt;
    logic memHitRt;
    logic stallRs;
    logic stallRt;
    logic stallMd;
    logic stallAny;

    // producer still too far from its result for this use
    assign exHitRs  = exValid && (exDest == addrRs) && (exTnew > tUseRs);
    assign memHitRs = memValid && (memDest == addrRs) && (memTnew > tUseRs);
    assign exHitRt  = exValid && (exDest == addrRt) && (exTnew > tUseRt);
    assign memHitRt = memValid && (memDest == addrRt) && (memTnew > tUseRt);

    assign stallRs = (addrRs != 5'd0) && (exHitRs || memHitRs); // $0 never waits
    assign stallRt = (addrRt != 5'd0) && (exHitRt || memHitRt);
    assign stallMd = mdBusy && (funcClass == funcMultDiv);

    assign stallAny = inValid && (stallRs || stallRt || stallMd);

    // a flush wins over any stall
    assign stallPc    = stallAny && !flush;
    assign stallId    = stallAny && !flush;
    assign stallClrEx = stallAny && !flush; // bubble into EX

    assign issue   = inValid && !stallAny && outReady && !flush;
    assign inReady = (!stallAny && outReady) || flush; // flush drops the ID instr

    // WB goes unchecked so a MEM producer is at most one cycle from its result
    always_comb begin
        if (!$isunknown({memValid, memTnew})) begin
            assert final (!memValid || memTnew <= 3'd1)
                else $error("stallDetect: MEM producer with Tnew %0d needs a WB check", memTnew);
        end
    end

endmodule

//--- hdl/flushControl.sv
`timescale 1ns/10ps
// flush control
// kernel-control flush, write disables and macro PC of the oldest valid instruction
module flushControl (
    input  logic [hazardPkg::widthKCtrl-1:0] kCtrl,
    input  logic                             stallClrEx,
    input  logic                             inValid,
    input  logic [31:0]                      inPc,
    input  logic                             exValid,
    input  logic [31:0]                      exPc,
    input  logic                             memValid,
    input  logic [31:0]                      memPc,
    output logic                             flush,
    output logic                             clrId,
    output logic                             clrEx,
    output logic                             clrMem,
    output logic                             clrWb,
    output logic                             disMultDiv,
    output logic                             disDm,
    output logic [31:0]                      macroPc
);
    import hazardPkg::*;

    assign flush = (kCtrl == kCtrlKText) || (kCtrl == kCtrlEret);

    assign clrId  = flush;
    assign clrEx  = flush || stallClrEx; // stall bubble shares the EX clear
    assign clrMem = flush;
    assign clrWb  = flush;

    // no memory or hi/lo write from a flushed instruction
    assign disMultDiv = flush;
    assign disDm      = flush;

    // oldest valid first
    assign macroPc = memValid ? memPc :
                     exValid  ? exPc  :
                     inValid  ? inPc  : 32'd0;

    always_comb begin
        if (!$isunknown(kCtrl)) begin
            assert final (kCtrl inside {kCtrlNone, kCtrlKText, kCtrlEret})
                else $error("flushControl: undefined kernel-control code %0d", kCtrl);
        end
    end

endmodule

//--- hdl/hazardUnitTop.sv
`timescale 1ns/10ps
// hazard unit top
// ID timing decode, EX/MEM/WB producer chain, stall detect and exception flush
module hazardUnitTop (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             inValid,
    input  hazardPkg::instrWord              inInstr,
    input  logic [31:0]                      inPc,
    input  logic                             mdBusy,
    input  logic [hazardPkg::widthKCtrl-1:0] kCtrl,
    input  logic                             outReady,
    output logic                             inReady,
    output logic                             outValid,
    output logic [4:0]                       outDest,
    output logic [hazardPkg::widthT-1:0]     outTnew,
    output logic                             stallPc,
    output logic                             stallId,
    output logic                             clrId,
    output logic                             clrEx,
    output logic                             clrMem,
    output logic                             clrWb,
    output logic                             disMultDiv,
    output logic                             disDm,
    output logic [31:0]                      macroPc
);
    import hazardPkg::*;

    logic [widthFunc-1:0] funcClass;
    logic [4:0]           idDest;
    logic [widthT-1:0]    tUseRs;
    logic [widthT-1:0]    tUseRt;
    logic [widthT-1:0]    tNewId;
    logic                 issue;
    logic                 stallClrEx;
    logic                 flush;
    logic                 advance;
    logic [numSlots-1:0]  slotValid;
    logic [4:0]           slotDest [numSlots];
    logic [widthT-1:0]    slotTnew [numSlots];
    logic [31:0]          slotPc [numSlots];

    assign advance = outReady || flush; // slots freeze under back-pressure

    instrTiming uTiming (
        .instr     (inInstr),
        .funcClass (funcClass),
        .dest      (idDest),
        .tUseRs    (tUseRs),
        .tUseRt    (tUseRt),
        .tNewId    (tNewId)
    );

    for (genvar k = 0; k < numSlots; k++) begin : gSlot
        logic              prevValid;
        logic [4:0]        prevDest;
        logic [widthT-1:0] prevTnew;
        logic [31:0]       prevPc;

        if (k == slotEx) begin : gHead
            // issued instr or bubble
            assign prevValid = issue;
            assign prevDest  = issue ? idDest : 5'd0;
            assign prevTnew  = issue ? tNewId : '0;
            assign prevPc    = inPc;
        end else begin : gChain
            assign prevValid = slotValid[k-1];
            assign prevDest  = slotDest[k-1];
            assign prevTnew  = slotTnew[k-1];
            assign prevPc    = slotPc[k-1];
        end

        producerSlot uSlot (
            .clk       (clk),
            .rstN      (rstN),
            .advance   (advance),
            .flush     (flush),
            .prevValid (prevValid),
            .prevDest  (prevDest),
            .prevTnew  (prevTnew),
            .prevPc    (prevPc),
            .countDown (1'b1),
            .valid     (slotValid[k]),
            .dest      (slotDest[k]),
            .tNew      (slotTnew[k]),
            .pc        (slotPc[k])
        );
    end

    stallDetect uStall (
        .addrRs     (inInstr.rType.rs),
        .addrRt     (inInstr.rType.rt),
        .tUseRs     (tUseRs),
        .tUseRt     (tUseRt),
        .funcClass  (funcClass),
        .exValid    (slotValid[slotEx]),
        .exDest     (slotDest[slotEx]),
        .exTnew     (slotTnew[slotEx]),
        .memValid   (slotValid[slotMem]),
        .memDest    (slotDest[slotMem]),
        .memTnew    (slotTnew[slotMem]),
        .mdBusy     (mdBusy),
        .inValid    (inValid),
        .outReady   (outReady),
        .flush      (flush),
        .stallPc    (stallPc),
        .stallId    (stallId),
        .stallClrEx (stallClrEx),
        .issue      (issue),
        .inReady    (inReady)
    );

    flushControl uFlush (
        .kCtrl      (kCtrl),
        .stallClrEx (stallClrEx),
        .inValid    (inValid),
        .inPc       (inPc),
        .exValid    (slotValid[slotEx]),
        .exPc       (slotPc[slotEx]),
        .memValid   (slotValid[slotMem]),
        .memPc      (slotPc[slotMem]),
        .flush      (flush),
        .clrId      (clrId),
        .clrEx      (clrEx),
        .clrMem     (clrMem),
        .clrWb      (clrWb),
        .disMultDiv (disMultDiv),
        .disDm      (disDm),
        .macroPc    (macroPc)
    );

    // output stream is the EX slot
    assign outValid = slotValid[slotEx];
    assign outDest  = slotDest[slotEx];
    assign outTnew  = slotTnew[slotEx];

endmodule

//--- test/hazardChecker.sv
`timescale 1ns/10ps
// hazard unit checker
// samples the DUT ports late in each cycle and compares them with the expected vector
module hazardChecker #(
    parameter int sampleDelay = 17 // ns after the rising edge
) (
    input  logic                         clk,
    input  logic                         checkEn,
    input  int                           vecIndex,
    input  logic                         inReady,
    input  logic                         stallPc,
    input  logic                         stallId,
    input  logic                         clrId,
    input  logic                         clrEx,
    input  logic                         clrMem,
    input  logic                         clrWb,
    input  logic                         disMultDiv,
    input  logic                         disDm,
    input  logic                         outValid,
    input  logic [4:0]                   outDest,
    input  logic [hazardPkg::widthT-1:0] outTnew,
    input  logic [31:0]                  macroPc,
    input  logic                         expInReady,
    input  logic                         expStallId,
    input  logic                         expClrEx,
    input  logic                         expClrMem,
    input  logic                         expOutValid,
    input  logic [4:0]                   expOutDest,
    input  logic [hazardPkg::widthT-1:0] expOutTnew,
    input  logic [31:0]                  expMacroPc,
    output int                           checkCount,
    output int                           mismatchCount
);

    initial begin
        checkCount    = 0;
        mismatchCount = 0;
    end

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            mismatchCount++;
            $display("Mismatch %s at vector %0d: expected %h, got %h",
                     name, vecIndex, expVal, actVal);
        end
    endtask

    always @(posedge clk) begin
        #sampleDelay; // just before the next edge
        if (checkEn) begin
            checkField("inReady", 32'(expInReady), 32'(inReady));
            checkField("stallId", 32'(expStallId), 32'(stallId));
            checkField("stallPc", 32'(expStallId), 32'(stallPc)); // same rule as stallId
            checkField("clrEx", 32'(expClrEx), 32'(clrEx));
            // every flush output follows the MEM clear
            checkField("clrMem", 32'(expClrMem), 32'(clrMem));
            checkField("clrId", 32'(expClrMem), 32'(clrId));
            checkField("clrWb", 32'(expClrMem), 32'(clrWb));
            checkField("disMultDiv", 32'(expClrMem), 32'(disMultDiv));
            checkField("disDm", 32'(expClrMem), 32'(disDm));
            checkField("outValid", 32'(expOutValid), 32'(outValid));
            checkField("outDest", 32'(expOutDest), 32'(outDest));
            checkField("outTnew", 32'(expOutTnew), 32'(outTnew));
            checkField("macroPc", expMacroPc, macroPc);
        end
    end

endmodule

//--- test/tbHazardUnit.sv
`timescale 1ns/10ps
// hazard unit testbench
// plays one stimulus vector per cycle from the data file into the DUT
module tbHazardUnit;
    import hazardPkg::*;

    localparam int clkPeriod   = 20;
    localparam int driveDelay  = 2;
    localparam int resetCycles = 10;
    localparam int numCols     = 13;
    localparam int maxVecs     = 128;

    logic                  clk;
    logic                  rstN;
    logic                  inValid;
    instrWord              inInstr;
    logic [31:0]           inPc;
    logic                  mdBusy;
    logic [widthKCtrl-1:0] kCtrl;
    logic                  outReady;
    logic                  inReady;
    logic                  outValid;
    logic [4:0]            outDest;
    logic [widthT-1:0]     outTnew;
    logic                  stallPc;
    logic                  stallId;
    logic                  clrId;
    logic                  clrEx;
    logic                  clrMem;
    logic                  clrWb;
    logic                  disMultDiv;
    logic                  disDm;
    logic [31:0]           macroPc;

    logic              expInReady;
    logic              expStallId;
    logic              expClrEx;
    logic              expClrMem;
    logic              expOutValid;
    logic [4:0]        expOutDest;
    logic [widthT-1:0] expOutTnew;
    logic [31:0]       expMacroPc;
    logic              checkEn;
    logic              loaded;
    int                vecIndex;
    int                numVecs;
    int                badLines;
    int                checkCount;
    int                mismatchCount;

    // columns 0..5 are inputs and 6..12 expected outputs
    logic [numCols-1:0][31:0] vecMem [maxVecs];

    always #(clkPeriod / 2) clk = ~clk;

    hazardUnitTop i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inInstr    (inInstr),
        .inPc       (inPc),
        .mdBusy     (mdBusy),
        .kCtrl      (kCtrl),
        .outReady   (outReady),
        .inReady    (inReady),
        .outValid   (outValid),
        .outDest    (outDest),
        .outTnew    (outTnew),
        .stallPc    (stallPc),
        .stallId    (stallId),
        .clrId      (clrId),
        .clrEx      (clrEx),
        .clrMem     (clrMem),
        .clrWb      (clrWb),
        .disMultDiv (disMultDiv),
        .disDm      (disDm),
        .macroPc    (macroPc)
    );

    hazardChecker #(.sampleDelay(clkPeriod - 3)) uChecker (
        .clk           (clk),
        .checkEn       (checkEn),
        .vecIndex      (vecIndex),
        .inReady       (inReady),
        .stallPc       (stallPc),
        .stallId       (stallId),
        .clrId         (clrId),
        .clrEx         (clrEx),
        .clrMem        (clrMem),
        .clrWb         (clrWb),
        .disMultDiv    (disMultDiv),
        .disDm         (disDm),
        .outValid      (outValid),
        .outDest       (outDest),
        .outTnew       (outTnew),
        .macroPc       (macroPc),
        .expInReady    (expInReady),
        .expStallId    (expStallId),
        .expClrEx      (expClrEx),
        .expClrMem     (expClrMem),
        .expOutValid   (expOutValid),
        .expOutDest    (expOutDest),
        .expOutTnew    (expOutTnew),
        .expMacroPc    (expMacroPc),
        .checkCount    (checkCount),
        .mismatchCount (mismatchCount)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic driveIdle();
        inValid  = 1'b0;
        inInstr  = '0;
        inPc     = 32'd0;
        mdBusy   = 1'b0;
        kCtrl    = kCtrlNone;
        outReady = 1'b1;
    endtask

    // Tnew of an issued producer once it sits in EX, one below its Tnew at ID
    function automatic logic [widthT-1:0] exTnewOf(input logic [31:0] word);
        logic [5:0]        op;
        logic [5:0]        fn;
        logic [4:0]        rt;
        logic [4:0]        rd;
        logic [widthT-1:0] tNew;
        op   = word[31:26];
        rt   = word[20:16];
        rd   = word[15:11];
        fn   = word[5:0];
        tNew = '0;
        case (op)
            6'h00: begin
                // SLL, MFLO, ADDU, SUBU
                if ((fn == 6'h00 || fn == 6'h12 || fn == 6'h21 || fn == 6'h23) &&
                    rd != 5'd0) begin
                    tNew = 3'd2;
                end
            end
            6'h0d:   tNew = (rt != 5'd0) ? 3'd2 : 3'd0; // ORI
            6'h0f:   tNew = (rt != 5'd0) ? 3'd1 : 3'd0; // LUI
            6'h23:   tNew = (rt != 5'd0) ? 3'd3 : 3'd0; // LW
            6'h03:   tNew = 3'd1;                       // JAL links into $31
            default: tNew = '0;
        endcase
        return (tNew != '0) ? tNew - 1'b1 : '0;
    endfunction

    // skips comment and blank lines and counts lines that do not parse
    task automatic readVectors(input int fd);
        string       line;
        int          nRead;
        logic [31:0] fld [numCols];
        while ($fgets(line, fd) != 0) begin
            if (line.len() >= 2 && line[0] != "/") begin
                nRead = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
                if (nRead != numCols || numVecs >= maxVecs) begin
                    badLines++;
                end else begin
                    for (int k = 0; k < numCols; k++) begin
                        vecMem[numVecs][k] = fld[k];
                    end
                    numVecs++;
                end
            end
        end
    endtask

    task automatic applyVector(input int idx);
        // EX Tnew after the edge just passed, from the vector driven before it
        if (kCtrl == kCtrlKText || kCtrl == kCtrlEret) begin
            expOutTnew = '0;
        end else if (outReady) begin
            expOutTnew = (inValid && expInReady) ? exTnewOf(inInstr) : '0;
        end
        inValid     = vecMem[idx][0][0];
        inInstr     = vecMem[idx][1];
        inPc        = vecMem[idx][2];
        mdBusy      = vecMem[idx][3][0];
        kCtrl       = vecMem[idx][4][widthKCtrl-1:0];
        outReady    = vecMem[idx][5][0];
        expInReady  = vecMem[idx][6][0];
        expStallId  = vecMem[idx][7][0];
        expClrEx    = vecMem[idx][8][0];
        expClrMem   = vecMem[idx][9][0];
        expOutValid = vecMem[idx][10][0];
        expOutDest  = vecMem[idx][11][4:0];
        expMacroPc  = vecMem[idx][12];
        vecIndex    = idx;
        checkEn     = 1'b1;
    endtask

    initial begin : mainFlow
        int fd;
        clk        = 1'b0;
        rstN       = 1'b0;
        checkEn    = 1'b0;
        loaded     = 1'b0;
        vecIndex   = 0;
        numVecs    = 0;
        badLines   = 0;
        expOutTnew = '0;
        driveIdle();
        fd = $fopen("test/hazard_stimulus.txt", "r");
        if (fd == 0) begin
            abortRun("could not open the stimulus file test/hazard_stimulus.txt");
        end else begin
            readVectors(fd);
            $fclose(fd);
            if (numVecs == 0 || badLines != 0) begin
                abortRun($sformatf("stimulus file unusable: %0d vectors, %0d bad lines",
                                   numVecs, badLines));
            end else begin
                loaded = 1'b1;
                repeat (resetCycles) @(posedge clk);
                #driveDelay;
                rstN = 1'b1;
                for (int i = 0; i < numVecs; i++) begin
                    @(posedge clk);
                    #driveDelay;
                    applyVector(i);
                end
                @(posedge clk);
                #driveDelay;
                checkEn = 1'b0; // last vector already sampled
                driveIdle();
                $display("vectors %0d, checks %0d, mismatches %0d",
                         numVecs, checkCount, mismatchCount);
                if (mismatchCount == 0) begin
                    $display("Simulation finished: PASS");
                end else begin
                    $display("Simulation finished: FAIL");
                end
                $finish;
            end
        end
    end

    // run length is reset + one cycle per vector, plus margin
    initial begin : watchdog
        wait (loaded);
        #((numVecs + resetCycles + 50) * clkPeriod);
        abortRun($sformatf("timeout: run did not end within %0d cycles",
                           numVecs + resetCycles + 50));
    end

endmodule

//--- project.f
common/hazardPkg.sv
hazardControl/instrTiming.sv
hazardControl/producerSlot.sv
hazardControl/stallDetect.sv
hdl/flushControl.sv
hdl/hazardUnitTop.sv
test/hazardChecker.sv
test/tbHazardUnit.sv

//--- test/hazard_stimulus.txt
// in: inValid inInstr inPc mdBusy kCtrl outReady
// exp: inReady stallId clrEx clrMem outValid outDest macroPc   (all hex)
1 00430821 00003000 0 0 1   1 0 0 0 0 00 00003000
1 34a40010 00003004 0 0 1   1 0 0 0 1 01 00003000
1 00e83023 00003008 0 0 1   1 0 0 0 1 04 00003000
0 00000000 00000000 0 0 1   1 0 0 0 1 06 00003004
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00003008
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00000000
1 8d490000 00003100 0 0 1   1 0 0 0 0 00 00003100
1 012c5821 00003104 0 0 1   0 1 1 0 1 09 00003100
1 012c5821 00003104 0 0 1   1 0 0 0 0 00 00003100
1 8dcd0000 00003108 0 0 1   1 0 0 0 1 0b 00003104
1 11a00004 0000310c 0 0 1   0 1 1 0 1 0d 00003104
1 11a00004 0000310c 0 0 1   0 1 1 0 0 00 00003108
1 11a00004 0000310c 0 0 1   1 0 0 0 0 00 0000310c
1 340f0001 00003110 0 0 1   1 0 0 0 1 00 0000310c
0 00000000 00000000 0 0 1   1 0 0 0 1 0f 0000310c
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00003110
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00000000
1 02110018 00003200 1 0 1   0 1 1 0 0 00 00003200
1 02110018 00003200 1 0 1   0 1 1 0 0 00 00003200
1 02110018 00003200 0 0 1   1 0 0 0 0 00 00003200
1 00009012 00003204 1 0 1   0 1 1 0 1 00 00003200
1 00009012 00003204 0 0 1   1 0 0 0 0 00 00003200
0 00000000 00000000 0 0 1   1 0 0 0 1 12 00003204
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00003204
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00000000
1 8e930000 00003300 0 0 1   1 0 0 0 0 00 00003300
1 0276a821 00003304 0 1 1   1 0 1 1 1 13 00003300
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00000000
1 37170020 00003400 0 0 1   1 0 0 0 0 00 00003400
1 02fac821 00003404 0 0 1   1 0 0 0 1 17 00003400
1 033cd823 00003408 0 2 1   1 0 1 1 1 19 00003400
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00000000
1 8c620004 00003500 0 0 1   1 0 0 0 0 00 00003500
1 00452021 00003504 0 0 0   0 1 1 0 1 02 00003500
1 00452021 00003504 0 0 0   0 1 1 0 1 02 00003500
1 00452021 00003504 0 0 0   0 1 1 0 1 02 00003500
1 00452021 00003504 0 0 1   0 1 1 0 1 02 00003500
1 00452021 00003504 0 0 1   1 0 0 0 0 00 00003500
0 00000000 00000000 0 0 0   0 0 0 0 1 04 00003504
0 00000000 00000000 0 0 0   0 0 0 0 1 04 00003504
0 00000000 00000000 0 0 1   1 0 0 0 1 04 00003504
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00003504
0 00000000 00000000 0 0 1   1 0 0 0 0 00 00000000
